// File: common/sddac_pkg.sv
/* Shared definitions of the sigma-delta DAC front end
   Sample widths, halfband coefficients, MAC opcodes and sequencer steps */
package sddac_pkg;

    localparam int SAMPLE_W = 18;
    localparam int NUM_TAPS = 34;
    localparam int TAP_W    = 6;
    localparam int XMID_OFS = 17;
    localparam int ACC_W    = 48;
    localparam int RES_LSB  = 16;

    // --------------------
    // Halfband coefficients symmetric around taps 16 and 17
    localparam logic signed [SAMPLE_W-1:0] HB_COEFS [NUM_TAPS] = '{
        18'sh00002, 18'sh3FFF6, 18'sh0001A, 18'sh3FFC5, 18'sh00071, 18'sh3FF36,
        18'sh0014E, 18'sh3FDEF, 18'sh00322, 18'sh3FB62, 18'sh006A5, 18'sh3F68B,
        18'sh00D71, 18'sh3EC88, 18'sh01DC3, 18'sh3CB6A, 18'sh0A263, 18'sh0A263,
        18'sh3CB6A, 18'sh01DC3, 18'sh3EC88, 18'sh00D71, 18'sh3F68B, 18'sh006A5,
        18'sh3FB62, 18'sh00322, 18'sh3FDEF, 18'sh0014E, 18'sh3FF36, 18'sh00071,
        18'sh3FFC5, 18'sh0001A, 18'sh3FFF6, 18'sh00002
    };

    // --------------------
    // Data types
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] l;
        logic signed [SAMPLE_W-1:0] r;
    } stereo_t;

    typedef enum logic [1:0] {
        ALU_NOP = 2'd0,
        ALU_MUL = 2'd1,
        ALU_MAC = 2'd2
    } alu_op_t;

    typedef struct packed {
        alu_op_t                    op;
        logic signed [SAMPLE_W-1:0] a;
        logic signed [SAMPLE_W-1:0] b;
    } dsp_req_t;

    typedef enum logic [3:0] {
        HB_INIT,
        HB_WAIT,
        HB_PUSH,
        HB_MAC,
        HB_DRAIN0,
        HB_DRAIN1,
        HB_RES_AC,
        HB_RES_MID,
        HB_JUMP
    } hb_state_t;

endpackage

// File: verilog/dp_ram.sv
/* Generic dual-port RAM
   One synchronous write port and one registered read port */
`timescale 1ns/100ps

module dp_ram #(
    parameter int DATA_W = 36,
    parameter int DEPTH  = 34,
    parameter int ADDR_W = 6
) (
    input  logic              clk,
    input  logic              wr,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              rd,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data holds between reads
    always_ff @(posedge clk) begin
        if (rd) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: verilog/alu_dsp.sv
/* Multiply-accumulate unit
   Registers the request, then loads or accumulates the product */
`timescale 1ns/100ps

module alu_dsp
    import sddac_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  dsp_req_t                req,
    output logic signed [ACC_W-1:0] acc
);

    alu_op_t                      op_q;
    logic signed [SAMPLE_W-1:0]   a_q;
    logic signed [SAMPLE_W-1:0]   b_q;
    logic signed [2*SAMPLE_W-1:0] prod;

    // --------------------
    // Input stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_q <= ALU_NOP;
        end else begin
            op_q <= req.op;
        end
    end

    always_ff @(posedge clk) begin
        a_q <= req.a;
        b_q <= req.b;
    end

    assign prod = a_q * b_q;

    // --------------------
    // Accumulator
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc <= '0;
        end else begin
            case (op_q)
                ALU_MUL: acc <= prod;
                ALU_MAC: acc <= acc + prod;
                default: acc <= acc;
            endcase
        end
    end

    a_op_legal: assert property (
        @(posedge clk) disable iff (reset)
        op_q inside {ALU_NOP, ALU_MUL, ALU_MAC}
    );

endmodule

// File: halfband/hb_coef_rom.sv
/* Halfband coefficient ROM
   Registered lookup by tap index with zero past the last tap */
`timescale 1ns/100ps

module hb_coef_rom
    import sddac_pkg::*;
(
    input  logic                       clk,
    input  logic [TAP_W-1:0]           tap,
    output logic signed [SAMPLE_W-1:0] coef
);

    logic tap_ok;

    assign tap_ok = (tap < TAP_W'(NUM_TAPS));

    // Same latency as the delay-line read
    always_ff @(posedge clk) begin
        if (tap_ok) begin
            coef <= HB_COEFS[tap];
        end else begin
            coef <= '0;
        end
    end

endmodule

// File: halfband/hb_interp_2x.sv
/* Microcoded halfband 2x interpolator
   Runs the 34-tap FIR on two MACs, then emits the center sample */
`timescale 1ns/100ps

module hb_interp_2x
    import sddac_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_in_rdy,
    input  stereo_t                 sample_in,
    input  logic signed [ACC_W-1:0] acc_l,
    input  logic signed [ACC_W-1:0] acc_r,
    output logic                    sample_out_rdy,
    output stereo_t                 sample_out,
    output logic                    done,
    output dsp_req_t                dsp_req_l,
    output dsp_req_t                dsp_req_r
);

    hb_state_t                  state;
    logic [TAP_W-1:0]           rpt_cnt;
    logic                       rpt_last;
    stereo_t                    sample_reg;
    logic [TAP_W-1:0]           i_idx;
    logic [TAP_W-1:0]           j_idx;
    logic [TAP_W-1:0]           head;
    logic [TAP_W-1:0]           mid;
    logic [TAP_W-1:0]           head_nxt;
    logic [TAP_W-1:0]           mid_nxt;
    alu_op_t                    op_d;
    logic                       x_wr;
    logic                       x_rd;
    logic [TAP_W-1:0]           x_wr_addr;
    logic [TAP_W-1:0]           x_rd_addr;
    stereo_t                    x_wr_data;
    stereo_t                    x_rd_data;
    logic signed [SAMPLE_W-1:0] coef;

    always_ff @(posedge clk) begin
        if (sample_in_rdy) begin
            sample_reg <= sample_in;
        end
    end

    // --------------------
    // Sequencer
    assign rpt_last = (rpt_cnt == TAP_W'(NUM_TAPS - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rpt_cnt <= '0;
        end else if ((state == HB_INIT || state == HB_MAC) && !rpt_last) begin
            rpt_cnt <= rpt_cnt + 1'b1;
        end else begin
            rpt_cnt <= '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= HB_INIT;
        end else begin
            case (state)
                HB_INIT:    state <= rpt_last ? HB_WAIT : HB_INIT;
                HB_WAIT:    state <= sample_in_rdy ? HB_PUSH : HB_WAIT;
                HB_PUSH:    state <= HB_MAC;
                HB_MAC:     state <= rpt_last ? HB_DRAIN0 : HB_MAC;
                HB_DRAIN0:  state <= HB_DRAIN1;
                HB_DRAIN1:  state <= HB_RES_AC;
                HB_RES_AC:  state <= HB_RES_MID;
                HB_RES_MID: state <= HB_JUMP;
                default:    state <= HB_WAIT;
            endcase
        end
    end

    // --------------------
    // Delay-line pointers
    // Tap k sits at head+k since each new sample goes one slot lower
    assign head_nxt = (head == '0) ? TAP_W'(NUM_TAPS - 1) : head - 1'b1;
    assign mid_nxt  = (mid == '0) ? TAP_W'(NUM_TAPS - 1) : mid - 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head <= '0;
            mid  <= TAP_W'(XMID_OFS);
        end else if (state == HB_PUSH) begin
            head <= head_nxt;
            mid  <= mid_nxt;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            i_idx <= '0;
            j_idx <= '0;
        end else if (state == HB_PUSH) begin
            i_idx <= '0;
            j_idx <= head_nxt;
        end else if (state == HB_MAC) begin
            i_idx <= i_idx + 1'b1;
            j_idx <= (j_idx == TAP_W'(NUM_TAPS - 1)) ? '0 : j_idx + 1'b1;
        end
    end

    // Init writes zeros over the whole line
    assign x_wr      = (state == HB_INIT) || (state == HB_PUSH);
    assign x_wr_addr = (state == HB_INIT) ? rpt_cnt : head_nxt;
    assign x_wr_data = (state == HB_INIT) ? '0 : sample_reg;
    assign x_rd      = (state == HB_MAC) || (state == HB_RES_AC);
    assign x_rd_addr = (state == HB_RES_AC) ? mid : j_idx;

    dp_ram #(
        .DATA_W ($bits(stereo_t)),
        .DEPTH  (NUM_TAPS),
        .ADDR_W (TAP_W)
    ) x_buf_ram (
        .clk     (clk),
        .wr      (x_wr),
        .wr_addr (x_wr_addr),
        .wr_data (x_wr_data),
        .rd      (x_rd),
        .rd_addr (x_rd_addr),
        .rd_data (x_rd_data)
    );

    hb_coef_rom u_coef_rom (
        .clk  (clk),
        .tap  (i_idx),
        .coef (coef)
    );

    // --------------------
    // MAC requests with the opcode lined up to the registered reads
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_d <= ALU_NOP;
        end else if (state == HB_MAC) begin
            op_d <= (i_idx == '0) ? ALU_MUL : ALU_MAC;
        end else begin
            op_d <= ALU_NOP;
        end
    end

    always_comb begin
        dsp_req_l.op = op_d;
        dsp_req_l.a  = coef;
        dsp_req_l.b  = x_rd_data.l;
        dsp_req_r.op = op_d;
        dsp_req_r.a  = coef;
        dsp_req_r.b  = x_rd_data.r;
    end

    // --------------------
    // Output pair
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_out_rdy <= 1'b0;
            sample_out     <= '0;
            done           <= 1'b0;
        end else begin
            sample_out_rdy <= 1'b0;
            sample_out     <= '0;
            done           <= 1'b0;
            if (state == HB_RES_AC) begin
                sample_out_rdy <= 1'b1;
                sample_out.l   <= acc_l[RES_LSB +: SAMPLE_W];
                sample_out.r   <= acc_r[RES_LSB +: SAMPLE_W];
            end else if (state == HB_RES_MID) begin
                // Halfband shortcut
                sample_out_rdy <= 1'b1;
                sample_out     <= x_rd_data;
                done           <= 1'b1;
            end
        end
    end

    a_strobe_in_wait: assert property (
        @(posedge clk) disable iff (reset)
        sample_in_rdy |-> state == HB_WAIT
    );

    a_done_second: assert property (
        @(posedge clk) disable iff (reset)
        done |-> sample_out_rdy && $past(sample_out_rdy)
    );

endmodule

// File: sdm/sdm_first_order.sv
/* First-order sigma-delta modulator, two channels
   One output bit per clock from the carry of an error accumulator */
`timescale 1ns/100ps

module sdm_first_order
    import sddac_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       sample_rdy,
    input  stereo_t    sample,
    output logic [1:0] dac_bits
);

    // Index 1 is left, 0 is right
    logic [1:0][SAMPLE_W-1:0] smp;
    logic [1:0][SAMPLE_W-1:0] held;
    logic [1:0][SAMPLE_W-1:0] acc;
    logic [1:0][SAMPLE_W:0]   sum;

    assign smp = sample;

    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            sum[ch] = {1'b0, acc[ch]} + {1'b0, held[ch]};
        end
    end

    // Held value is offset binary with zero at full negative scale
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            held <= '0;
        end else if (sample_rdy) begin
            for (int ch = 0; ch < 2; ch++) begin
                held[ch] <= {~smp[ch][SAMPLE_W-1], smp[ch][SAMPLE_W-2:0]};
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc      <= '0;
            dac_bits <= '0;
        end else begin
            for (int ch = 0; ch < 2; ch++) begin
                acc[ch]      <= sum[ch][SAMPLE_W-1:0];
                dac_bits[ch] <= sum[ch][SAMPLE_W];
            end
        end
    end

endmodule

// File: verilog/sddac_top.sv
/* Sigma-delta DAC front end
   Halfband interpolator, two MAC units and the bitstream modulator */
`timescale 1ns/100ps

module sddac_top
    import sddac_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       sample_in_rdy,
    input  stereo_t    sample_in,
    output logic       sample_out_rdy,
    output stereo_t    sample_out,
    output logic       done,
    output logic [1:0] dac_bits
);

    dsp_req_t                dsp_req_l;
    dsp_req_t                dsp_req_r;
    logic signed [ACC_W-1:0] acc_l;
    logic signed [ACC_W-1:0] acc_r;

    hb_interp_2x u_interp (
        .clk            (clk),
        .reset          (reset),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .acc_l          (acc_l),
        .acc_r          (acc_r),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out),
        .done           (done),
        .dsp_req_l      (dsp_req_l),
        .dsp_req_r      (dsp_req_r)
    );

    alu_dsp mac_l (
        .clk   (clk),
        .reset (reset),
        .req   (dsp_req_l),
        .acc   (acc_l)
    );

    alu_dsp mac_r (
        .clk   (clk),
        .reset (reset),
        .req   (dsp_req_r),
        .acc   (acc_r)
    );

    sdm_first_order u_sdm (
        .clk        (clk),
        .reset      (reset),
        .sample_rdy (sample_out_rdy),
        .sample     (sample_out),
        .dac_bits   (dac_bits)
    );

endmodule

// File: testbench/sddac_model.svh
/* Reference model of the DAC front end
   Input history, FIR and center-tap outputs, modulator bitstream */
`ifndef SDDAC_MODEL_SVH
`define SDDAC_MODEL_SVH

// Index k holds the input from k samples back
stereo_t             hist     [NUM_TAPS];
logic [SAMPLE_W-1:0] sdm_acc  [2];
logic [SAMPLE_W-1:0] sdm_held [2];

function automatic void clear_history();
    for (int k = 0; k < NUM_TAPS; k++) begin
        hist[k] = '0;
    end
endfunction

function automatic void push_history(input stereo_t s);
    for (int k = NUM_TAPS - 1; k > 0; k--) begin
        hist[k] = hist[k-1];
    end
    hist[0] = s;
endfunction

// --------------------
// Filtered output as bits 33..16 of the full-precision sum
function automatic logic [SAMPLE_W-1:0] fir_channel(input bit left);
    logic signed [63:0] sum;
    logic signed [63:0] x;
    logic signed [63:0] c;
    sum = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
        x   = left ? hist[k].l : hist[k].r;
        c   = HB_COEFS[k];
        sum = sum + c * x;
    end
    return sum[RES_LSB +: SAMPLE_W];
endfunction

function automatic stereo_t fir_expected();
    stereo_t res;
    res.l = fir_channel(1'b1);
    res.r = fir_channel(1'b0);
    return res;
endfunction

function automatic stereo_t mid_expected();
    return hist[XMID_OFS];
endfunction

// --------------------
// Modulator
function automatic void sdm_clear();
    for (int ch = 0; ch < 2; ch++) begin
        sdm_acc[ch]  = '0;
        sdm_held[ch] = '0;
    end
endfunction

// One clock of both channels with bit 1 as left
function automatic logic [1:0] sdm_step(input logic rdy, input stereo_t s);
    logic [31:0]         total;
    logic [SAMPLE_W-1:0] smp;
    logic [1:0]          bits;
    for (int ch = 0; ch < 2; ch++) begin
        total       = 32'(sdm_acc[ch]) + 32'(sdm_held[ch]);
        bits[ch]    = (total >= (32'd1 << SAMPLE_W));
        sdm_acc[ch] = total[SAMPLE_W-1:0];
        if (rdy) begin
            smp          = (ch == 1) ? s.l : s.r;
            sdm_held[ch] = smp ^ (SAMPLE_W'(1) << (SAMPLE_W - 1));
        end
    end
    return bits;
endfunction

`endif

// File: testbench/sddac_tb.sv
/* Testbench of the sigma-delta DAC front end
   Random stereo input, checked by concurrent assertions against a model */
`timescale 1ns/100ps

module sddac_tb
    import sddac_pkg::*;
();

    localparam int NUM_SAMPLES = 60;
    localparam int INIT_LIMIT  = 200;
    localparam int PAIR_LIMIT  = 100;

    logic       clk;
    logic       reset;
    logic       sample_in_rdy;
    stereo_t    sample_in;
    logic       sample_out_rdy;
    stereo_t    sample_out;
    logic       done;
    logic [1:0] dac_bits;

    logic       clearing;
    logic       aborted;
    stereo_t    exp_fir;
    stereo_t    exp_mid;
    logic [1:0] exp_dac;
    logic       prev_rdy;
    stereo_t    prev_smp;
    int         value_errs;
    int         timing_errs;
    int         timeouts;

    `include "sddac_model.svh"

    sddac_top DUT (
        .clk            (clk),
        .reset          (reset),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out),
        .done           (done),
        .dac_bits       (dac_bits)
    );

    always #4 clk = ~clk;

    // Model mirrors the edge just before each falling edge
    always @(negedge clk) begin
        if (reset) begin
            sdm_clear();
            exp_dac  = 2'b00;
            prev_rdy = 1'b0;
            prev_smp = '0;
        end else begin
            exp_dac  = sdm_step(prev_rdy, prev_smp);
            prev_rdy = sample_out_rdy;
            prev_smp = sample_out;
        end
    end

    // --------------------
    a_first_rdy: assert property (@(posedge clk) disable iff (reset)
        sample_in_rdy |-> ##39 (sample_out_rdy && !done))
    else begin
        timing_errs++;
        $display("Filtered output strobe missing 39 cycles after input at %0t", $time);
    end

    a_first_val: assert property (@(posedge clk) disable iff (reset)
        sample_in_rdy |-> ##39 (sample_out == exp_fir))
    else begin
        value_errs++;
        $display("** Error sample_out: got %h, expected %h",
                 $sampled(sample_out), $sampled(exp_fir));
    end

    a_second_rdy: assert property (@(posedge clk) disable iff (reset)
        sample_in_rdy |-> ##40 (sample_out_rdy && done))
    else begin
        timing_errs++;
        $display("Center output or done missing 40 cycles after input at %0t", $time);
    end

    a_second_val: assert property (@(posedge clk) disable iff (reset)
        sample_in_rdy |-> ##40 (sample_out == exp_mid))
    else begin
        value_errs++;
        $display("** Error sample_out: got %h, expected %h",
                 $sampled(sample_out), $sampled(exp_mid));
    end

    a_no_stray: assert property (@(posedge clk) disable iff (reset)
        sample_out_rdy |-> ($past(sample_in_rdy, 39) || $past(sample_in_rdy, 40)))
    else begin
        timing_errs++;
        $display("Output strobe with no matching input at %0t", $time);
    end

    a_done_late: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(sample_in_rdy, 40))
    else begin
        timing_errs++;
        $display("done pulsed outside the second output at %0t", $time);
    end

    a_quiet_init: assert property (@(posedge clk) disable iff (reset)
        clearing |-> (!sample_out_rdy && !done && dac_bits == 2'b00))
    else begin
        timing_errs++;
        $display("Output activity during delay-line clearing at %0t", $time);
    end

    a_dac: assert property (@(posedge clk) disable iff (reset)
        dac_bits == exp_dac)
    else begin
        value_errs++;
        $display("** Error dac_bits: got %h, expected %h",
                 $sampled(dac_bits), $sampled(exp_dac));
    end

    // --------------------
    initial begin
        int      gap;
        int      cycles;
        stereo_t s;
        void'($urandom(26));
        clk           = 1'b0;
        reset         = 1'b1;
        sample_in_rdy = 1'b0;
        sample_in     = '0;
        clearing      = 1'b1;
        aborted       = 1'b0;
        exp_fir       = '0;
        exp_mid       = '0;
        exp_dac       = 2'b00;
        value_errs    = 0;
        timing_errs   = 0;
        timeouts      = 0;
        clear_history();
        sdm_clear();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (DUT.u_interp.state != HB_WAIT && !aborted) begin
            @(negedge clk);
            cycles++;
            if (cycles > INIT_LIMIT) begin
                $display("Timeout: delay line clearing never finished");
                timeouts++;
                aborted = 1'b1;
            end
        end
        clearing = 1'b0;

        for (int n = 0; n < NUM_SAMPLES && !aborted; n++) begin
            s.l = SAMPLE_W'($urandom);
            s.r = SAMPLE_W'($urandom);
            gap = $urandom_range(60, 41);
            push_history(s);
            exp_fir = fir_expected();
            exp_mid = mid_expected();
            sample_in_rdy <= 1'b1;
            sample_in     <= s;
            @(negedge clk);
            sample_in_rdy <= 1'b0;
            cycles = 1;
            while (!done && !aborted) begin
                @(negedge clk);
                cycles++;
                if (cycles > PAIR_LIMIT) begin
                    $display("Timeout: no done after input %0d", n);
                    timeouts++;
                    aborted = 1'b1;
                end
            end
            while (cycles < gap) begin
                @(negedge clk);
                cycles++;
            end
        end

        // Let the modulator run on the last sample
        repeat (20) @(negedge clk);
        $display("Errors: %0d value, %0d timing, %0d timeout",
                 value_errs, timing_errs, timeouts);
        if (value_errs + timing_errs + timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sddac.f
+incdir+testbench
common/sddac_pkg.sv
verilog/dp_ram.sv
verilog/alu_dsp.sv
halfband/hb_coef_rom.sv
halfband/hb_interp_2x.sv
sdm/sdm_first_order.sv
verilog/sddac_top.sv
testbench/sddac_tb.sv
